// File: project.f
rtl/lc4_pkg.sv
rtl/lc4_wb_if.sv
rtl/lc4_pc.sv
rtl/lc4_decoder.sv
rtl/lc4_regfile.sv
rtl/lc4_alu.sv
rtl/lc4_hazard.sv
rtl/lc4_processor.sv
tests/lc4_asserts.sv
tests/lc4_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the LC4 pipeline testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module lc4_tb -f project.f -o lc4_sim
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/lc4_sim
status=$?
if [ $status -ne 0 ]; then
  echo "simulation returned status $status"
  exit $status
fi
exit 0

// File: tests/lc4_tb.sv
`timescale 1ns/1ns
`default_nettype none

module lc4_tb import lc4_pkg::*; ;

  localparam int    RESET_CYCLES = 8;
  localparam int    PROG_LEN     = 200;          // Random instructions from the reset PC
  localparam int    NUM_RETIRE   = 400;          // Run length in retired instructions
  localparam int    WATCHDOG_CYC = (8 + 3 * NUM_RETIRE) * 2;
  localparam word_t PROG_BASE    = 16'h8200;

  logic     gwe = 1'b0;
  logic     i_rst;
  word_t    o_cur_pc, i_cur_insn, o_dmem_addr, i_cur_dmem_data, o_dmem_towrite;
  logic     o_dmem_we;
  stall_t   o_test_stall;
  word_t    o_test_cur_pc, o_test_cur_insn, o_test_regfile_data;
  logic     o_test_regfile_we, o_test_nzp_we, o_test_dmem_we;
  reg_sel_t o_test_regfile_wsel;
  nzp_t     o_test_nzp_new_bits;
  word_t    o_test_dmem_addr, o_test_dmem_data;

  integer   seed = 32'h1d3a40b4;
  word_t    imem [PROG_LEN];
  word_t    dmem [256];                          // Low 8 address bits only
  // ISA model state
  word_t    ref_regs [8];
  nzp_t     ref_nzp;
  word_t    ref_dmem [256];
  word_t    ref_pc;
  // Expected retirement fields
  logic     exp_reg_we, exp_nzp_we, exp_dmem_we, exp_taken;
  reg_sel_t exp_wsel;
  word_t    exp_reg_data, exp_dmem_addr, exp_dmem_data;
  nzp_t     exp_nzp;
  // Bubble bookkeeping between retirements
  int       retired = 0;
  int       n_flush = 0;
  int       n_load  = 0;
  logic     prev_taken = 1'b0;
  logic     prev_load  = 1'b0;
  reg_sel_t prev_rd    = '0;
  // Data memory port as driven one cycle before the same instruction retires
  logic     port_we   = 1'b0;
  word_t    port_addr = '0;
  word_t    port_data = '0;

  always #2 gwe = ~gwe;  // 4 ns period

  lc4_processor #(.P_RESET_PC(PROG_BASE)) lc4_processor_i (.*);

  bind lc4_processor lc4_asserts asserts_i (
    .gwe(gwe), .i_rst(i_rst), .o_test_stall(o_test_stall),
    .o_test_regfile_we(o_test_regfile_we), .o_test_nzp_we(o_test_nzp_we),
    .o_test_dmem_we(o_test_dmem_we), .o_dmem_we(o_dmem_we), .m_insn(m_insn)
  );

  function automatic word_t fetch(input word_t addr);
    word_t off;
    off = addr - PROG_BASE;
    if (addr >= PROG_BASE && off < PROG_LEN) return imem[off[7:0]];
    return '0;                                   // NOP outside the program
  endfunction

  // Both memories read combinationally
  always_comb i_cur_insn = fetch(o_cur_pc);
  always_comb i_cur_dmem_data = dmem[o_dmem_addr[7:0]];

  always @(posedge gwe) begin
    if (o_dmem_we) dmem[o_dmem_addr[7:0]] <= o_dmem_towrite;
  end

  function automatic nzp_t nzp_of(input word_t v);
    nzp_t r;
    r[2] = v[15];                                // Negative
    r[1] = (v == 16'h0000);
    r[0] = !v[15] && (v != 16'h0000);
    return r;
  endfunction

  // Registers an instruction reads in decode apart from store data
  function automatic logic reads_reg(input word_t insn, input reg_sel_t r);
    logic rs_hit, rt_hit;
    rs_hit = (insn[8:6] == r);
    rt_hit = (insn[2:0] == r);
    case (insn[15:12])
      4'b0001: return rs_hit || (!insn[5] && rt_hit);
      4'b0101: return rs_hit || (!insn[5] && insn[4:3] != 2'b01 && rt_hit);
      4'b0110, 4'b0111: return rs_hit;
      default: return 1'b0;
    endcase
  endfunction

  task automatic check(input string name, input word_t exp, input word_t act);
    if (exp !== act) begin
      $display("mismatch %s expected %h actual %h", name, exp, act);
      $display("SIMULATION FAILED");
      $fatal(1);
    end
  endtask

  task automatic build_program;
    int kind;
    logic [2:0] rd, rs, rt;
    logic [5:0] off6;
    for (int i = 0; i < 8; i++) begin            // Seed every register first
      imem[i] = {4'b1001, i[2:0], 9'($random(seed))};
    end
    for (int i = 8; i < PROG_LEN; i++) begin
      kind = $unsigned($random(seed)) % 13;
      rd   = 3'($unsigned($random(seed)) % 7);   // r7 stays a fixed base
      rs   = 3'($random(seed));
      rt   = 3'($random(seed));
      if ($random(seed) & 1) begin               // Hit a few shared addresses
        rs   = 3'd7;
        off6 = 6'($unsigned($random(seed)) % 4);
      end else begin
        off6 = 6'($random(seed));
      end
      case (kind)
        0:  imem[i] = {4'b0001, rd, rs, 3'b000, rt};  // ADD
        1:  imem[i] = {4'b0001, rd, rs, 3'b010, rt};  // SUB
        2:  imem[i] = {4'b0001, rd, rs, 1'b1, 5'($random(seed))};
        3:  imem[i] = {4'b0101, rd, rs, 3'b000, rt};  // AND
        4:  imem[i] = {4'b0101, rd, rs, 3'b001, rt};  // NOT
        5:  imem[i] = {4'b0101, rd, rs, 3'b010, rt};  // OR
        6:  imem[i] = {4'b0101, rd, rs, 3'b011, rt};  // XOR
        7:  imem[i] = {4'b0101, rd, rs, 1'b1, 5'($random(seed))};
        8:  imem[i] = {4'b1001, rd, 9'($random(seed))};
        9, 10: imem[i] = {4'b0110, rd, rs, off6};     // LDR
        11: imem[i] = {4'b0111, rt, rs, off6};        // STR
        default: imem[i] = {4'b0000, 3'($random(seed)),
                            9'(1 + $unsigned($random(seed)) % 8)};  // Forward BR
      endcase
    end
  endtask

  task automatic step_model(input word_t insn);
    word_t a, b, res, addr;
    reg_sel_t rd;
    rd  = insn[11:9];
    a   = ref_regs[insn[8:6]];
    b   = ref_regs[insn[2:0]];
    res = '0;
    exp_reg_we  = 1'b0;
    exp_dmem_we = 1'b0;
    exp_taken   = 1'b0;
    exp_dmem_addr = '0;
    exp_dmem_data = '0;
    case (insn[15:12])
      4'b0000: exp_taken = |(insn[11:9] & ref_nzp);
      4'b0001: begin
        exp_reg_we = insn[5] || (insn[4:3] == 2'b00) || (insn[4:3] == 2'b10);
        if (insn[5]) res = a + {{11{insn[4]}}, insn[4:0]};
        else if (insn[4]) res = a - b;
        else res = a + b;
      end
      4'b0101: begin
        exp_reg_we = 1'b1;
        if (insn[5]) res = a & {{11{insn[4]}}, insn[4:0]};
        else case (insn[4:3])
          2'b00:   res = a & b;
          2'b01:   res = ~a;
          2'b10:   res = a | b;
          default: res = a ^ b;
        endcase
      end
      4'b0110: begin
        addr = a + {{10{insn[5]}}, insn[5:0]};
        res  = ref_dmem[addr[7:0]];
        exp_reg_we = 1'b1;
        exp_dmem_addr = addr;
        exp_dmem_data = res;                     // Loaded value shows on the data field
      end
      4'b0111: begin
        addr = a + {{10{insn[5]}}, insn[5:0]};
        exp_dmem_we   = 1'b1;
        exp_dmem_addr = addr;
        exp_dmem_data = ref_regs[rd];
        ref_dmem[addr[7:0]] = ref_regs[rd];
      end
      4'b1001: begin
        exp_reg_we = 1'b1;
        res = {{7{insn[8]}}, insn[8:0]};
      end
      default: ;
    endcase
    exp_nzp_we   = exp_reg_we;                   // Every writer in the subset sets NZP
    exp_wsel     = rd;
    exp_reg_data = res;
    exp_nzp      = nzp_of(res);
    if (exp_reg_we) begin
      ref_regs[rd] = res;
      ref_nzp      = exp_nzp;
    end
    ref_pc = exp_taken ? ref_pc + 16'd1 + {{7{insn[8]}}, insn[8:0]} : ref_pc + 16'd1;
  endtask

  task automatic check_cycle;
    word_t insn;
    if (o_test_stall == STALL_NONE) begin
      insn = fetch(ref_pc);
      if (retired > 0) begin                     // Bubbles since the previous retirement
        check("flush bubbles", prev_taken ? 16'd2 : 16'd0, 16'(n_flush));
        check("load bubbles", (prev_load && reads_reg(insn, prev_rd)) ? 16'd1 : 16'd0,
              16'(n_load));
      end
      check("pc", ref_pc, o_test_cur_pc);
      check("insn", insn, o_test_cur_insn);
      step_model(insn);
      check("regfile_we", 16'(exp_reg_we), 16'(o_test_regfile_we));
      if (exp_reg_we) begin
        check("regfile_wsel", 16'(exp_wsel), 16'(o_test_regfile_wsel));
        check("regfile_data", exp_reg_data, o_test_regfile_data);
      end
      check("nzp_we", 16'(exp_nzp_we), 16'(o_test_nzp_we));
      if (exp_nzp_we) check("nzp_bits", 16'(exp_nzp), 16'(o_test_nzp_new_bits));
      check("dmem_we", 16'(exp_dmem_we), 16'(o_test_dmem_we));
      check("dmem_addr", exp_dmem_addr, o_test_dmem_addr);
      check("dmem_data", exp_dmem_data, o_test_dmem_data);
      check("dmem port we", 16'(exp_dmem_we), 16'(port_we));
      check("dmem port addr", exp_dmem_addr, port_addr);  // Zero for non-memory insns
      if (exp_dmem_we) check("dmem port data", exp_dmem_data, port_data);
      prev_taken = exp_taken;
      prev_load  = (insn[15:12] == 4'b0110);
      prev_rd    = insn[11:9];
      n_flush    = 0;
      n_load     = 0;
      retired++;
    end else begin
      if (retired == 0) check("stall before first retire", 16'(STALL_FLUSH), 16'(o_test_stall));
      check("bubble regfile_we", 16'd0, 16'(o_test_regfile_we));
      check("bubble nzp_we", 16'd0, 16'(o_test_nzp_we));
      check("bubble dmem_we", 16'd0, 16'(o_test_dmem_we));
      check("bubble dmem port we", 16'd0, 16'(port_we));
      check("bubble dmem port addr", 16'd0, port_addr);
      if (o_test_stall == STALL_FLUSH) n_flush++;
      else if (o_test_stall == STALL_LOAD) n_load++;
      else check("bubble stall code", 16'(STALL_LOAD), 16'(o_test_stall));
    end
    port_we   = o_dmem_we;                       // Memory stage now, writeback next cycle
    port_addr = o_dmem_addr;
    port_data = o_dmem_towrite;
  endtask

  initial begin
    i_rst = 1'b1;
    build_program();
    for (int i = 0; i < 256; i++) begin          // Pattern over the full index
      dmem[i]     = 16'(i * 16'h0101) ^ 16'h5a3c;
      ref_dmem[i] = 16'(i * 16'h0101) ^ 16'h5a3c;
    end
    for (int i = 0; i < 8; i++) ref_regs[i] = '0;
    ref_nzp = '0;
    ref_pc  = PROG_BASE;
    repeat (RESET_CYCLES) @(posedge gwe);
    i_rst <= 1'b0;
    while (retired < NUM_RETIRE) begin
      @(negedge gwe);                            // Outputs settled mid-cycle
      check_cycle();
    end
    $display("SIMULATION PASSED");
    $finish;
  end

  initial begin
    repeat (WATCHDOG_CYC) @(posedge gwe);
    $display("timeout: only %0d of %0d instructions retired", retired, NUM_RETIRE);
    $display("SIMULATION FAILED");
    $fatal(1);
  end

endmodule

`default_nettype wire

// File: tests/lc4_asserts.sv
`timescale 1ns/1ns
`default_nettype none

module lc4_asserts import lc4_pkg::*; (
  input wire         gwe,
  input wire         i_rst,
  input wire stall_t o_test_stall,
  input wire         o_test_regfile_we,
  input wire         o_test_nzp_we,
  input wire         o_test_dmem_we,
  input wire         o_dmem_we,
  input wire word_t  m_insn               // Instruction in the memory stage
);

  // Code 1 is never produced
  a_stall_code: assert property (@(posedge gwe) disable iff (i_rst)
    o_test_stall != 2'd1)
    else $error("stall code 1 retired");

  // Bubbles write nothing
  a_bubble_quiet: assert property (@(posedge gwe) disable iff (i_rst)
    (o_test_stall != STALL_NONE) |-> !(o_test_regfile_we || o_test_nzp_we || o_test_dmem_we))
    else $error("write enable high on a bubble");

  a_store_only: assert property (@(posedge gwe) disable iff (i_rst)
    o_dmem_we |-> (m_insn[15:12] == OP_STR))  // Memory write only from STR
    else $error("data memory write from a non-store");

endmodule

`default_nettype wire

// File: rtl/lc4_processor.sv
`timescale 1ns/1ns
`default_nettype none

module lc4_processor import lc4_pkg::*; #(
  parameter word_t P_RESET_PC = 16'h8200
) (
  input  wire        gwe,
  input  wire        i_rst,
  output word_t      o_cur_pc,             // Fetch address
  input  wire word_t i_cur_insn,
  output word_t      o_dmem_addr,          // Zero unless load or store
  input  wire word_t i_cur_dmem_data,
  output logic       o_dmem_we,
  output word_t      o_dmem_towrite,
  output stall_t     o_test_stall,         // All o_test_ refer to the insn in writeback
  output word_t      o_test_cur_pc,
  output word_t      o_test_cur_insn,
  output logic       o_test_regfile_we,
  output reg_sel_t   o_test_regfile_wsel,
  output word_t      o_test_regfile_data,
  output logic       o_test_nzp_we,
  output nzp_t       o_test_nzp_new_bits,
  output logic       o_test_dmem_we,
  output word_t      o_test_dmem_addr,
  output word_t      o_test_dmem_data
);

  word_t    pc;
  word_t    pc_plus_one;
  logic     stall;          // Load-use, hold fetch and decode
  logic     flush;          // Taken branch in execute
  fwd_sel_t fwd_a;
  fwd_sel_t fwd_b;
  nzp_t     nzp_reg;
  // Decode stage
  word_t    d_pc, d_pc_plus_one, d_insn;
  stall_t   d_stall;
  reg_sel_t d_rs, d_rt, d_rd;
  ctrl_t    d_ctrl;
  alu_op_t  d_alu_op;
  word_t    d_imm, d_rs_data, d_rt_data;
  // Execute stage
  word_t    x_pc, x_pc_plus_one, x_insn, x_imm, x_a, x_b;
  stall_t   x_stall;
  reg_sel_t x_rs, x_rt, x_rd;
  ctrl_t    x_ctrl;
  alu_op_t  x_alu_op;
  word_t    x_op_a, x_op_b, x_result, x_target;
  // Memory stage
  word_t    m_pc, m_insn, m_result, m_b, m_store_data, m_data;
  stall_t   m_stall;
  reg_sel_t m_rt, m_rd;
  ctrl_t    m_ctrl;
  // Writeback stage
  word_t    w_pc, w_insn, w_result, w_mem_data;
  stall_t   w_stall;
  reg_sel_t w_rd;
  ctrl_t    w_ctrl;

  lc4_wb_if wb ();

  lc4_pc #(.P_RESET_PC(P_RESET_PC)) pc_i (
    .gwe(gwe), .i_rst(i_rst), .i_stall(stall), .i_redirect(flush),
    .i_target(x_target), .o_pc(pc), .o_pc_plus_one(pc_plus_one)
  );

  assign o_cur_pc = pc;

  // Fetch to decode, flushed entries become NOP bubbles
  always_ff @(posedge gwe) begin
    if (i_rst || flush) begin
      d_insn  <= '0;
      d_stall <= STALL_FLUSH;
    end else if (!stall) begin
      d_insn  <= i_cur_insn;
      d_stall <= STALL_NONE;
    end
  end

  always_ff @(posedge gwe) begin
    if (!stall) begin
      d_pc          <= pc;
      d_pc_plus_one <= pc_plus_one;
    end
  end

  lc4_decoder decoder_i (
    .i_insn(d_insn), .o_rs(d_rs), .o_rt(d_rt), .o_rd(d_rd),
    .o_ctrl(d_ctrl), .o_alu_op(d_alu_op), .o_imm(d_imm)
  );

  lc4_regfile regfile_i (
    .gwe(gwe), .i_rst(i_rst), .i_rs(d_rs), .i_rt(d_rt),
    .o_rs_data(d_rs_data), .o_rt_data(d_rt_data), .wb(wb.wr)
  );

  // Decode to execute, bubble on flush or load-use
  always_ff @(posedge gwe) begin
    if (i_rst || flush) begin
      x_ctrl  <= '0;
      x_insn  <= '0;
      x_stall <= STALL_FLUSH;
    end else if (stall) begin
      x_ctrl  <= '0;
      x_insn  <= '0;
      x_stall <= STALL_LOAD;
    end else begin
      x_ctrl  <= d_ctrl;
      x_insn  <= d_insn;
      x_stall <= d_stall;
    end
  end

  always_ff @(posedge gwe) begin
    x_pc          <= d_pc;
    x_pc_plus_one <= d_pc_plus_one;
    x_rs          <= d_rs;
    x_rt          <= d_rt;
    x_rd          <= d_rd;
    x_alu_op      <= d_alu_op;
    x_imm         <= d_imm;
    x_a           <= d_rs_data;
    x_b           <= d_rt_data;
  end

  lc4_hazard hazard_i (
    .i_d_rs(d_rs), .i_d_rt(d_rt), .i_d_ctrl(d_ctrl),
    .i_x_rs(x_rs), .i_x_rt(x_rt), .i_x_rd(x_rd), .i_x_ctrl(x_ctrl), .i_x_insn(x_insn),
    .i_m_rd(m_rd), .i_m_ctrl(m_ctrl), .i_m_result(m_data), .i_nzp_reg(nzp_reg),
    .wb(wb.snoop), .o_stall(stall), .o_flush(flush),
    .o_fwd_a(fwd_a), .o_fwd_b(fwd_b), .o_x_nzp()
  );

  // Operand bypass into execute
  function automatic word_t fwd_pick(input fwd_sel_t sel, input word_t reg_val,
                                     input word_t m_val, input word_t w_val);
    case (sel)
      FWD_MEM: return m_val;
      FWD_WB:  return w_val;
      default: return reg_val;
    endcase
  endfunction

  assign x_op_a = fwd_pick(fwd_a, x_a, m_result, wb.data);
  assign x_op_b = fwd_pick(fwd_b, x_b, m_result, wb.data);

  lc4_alu alu_i (
    .i_alu_op(x_alu_op), .i_ctrl(x_ctrl), .i_a(x_op_a), .i_b(x_op_b), .i_imm(x_imm),
    .i_pc_plus_one(x_pc_plus_one), .o_result(x_result), .o_target(x_target)
  );

  always_ff @(posedge gwe) begin
    if (i_rst) begin
      m_ctrl  <= '0;
      m_insn  <= '0;
      m_stall <= STALL_FLUSH;
    end else begin
      m_ctrl  <= x_ctrl;
      m_insn  <= x_insn;
      m_stall <= x_stall;
    end
  end

  always_ff @(posedge gwe) begin
    m_pc     <= x_pc;
    m_rt     <= x_rt;
    m_rd     <= x_rd;
    m_result <= x_result;   // Address for loads and stores
    m_b      <= x_op_b;
  end

  // Load directly ahead of a store supplies its data from writeback
  assign m_store_data   = (wb.we && (wb.sel == m_rt)) ? wb.data : m_b;
  assign m_data         = m_ctrl[CTRL_IS_LOAD] ? i_cur_dmem_data : m_result;
  assign o_dmem_we      = m_ctrl[CTRL_IS_STORE];
  assign o_dmem_towrite = m_store_data;
  assign o_dmem_addr    = (m_ctrl[CTRL_IS_LOAD] || m_ctrl[CTRL_IS_STORE]) ? m_result : '0;

  always_ff @(posedge gwe) begin
    if (i_rst) begin
      w_ctrl  <= '0;
      w_insn  <= '0;
      w_stall <= STALL_FLUSH;
    end else begin
      w_ctrl  <= m_ctrl;
      w_insn  <= m_insn;
      w_stall <= m_stall;
    end
  end

  always_ff @(posedge gwe) begin
    w_pc       <= m_pc;
    w_rd       <= m_rd;
    w_result   <= m_result;
    w_mem_data <= m_ctrl[CTRL_IS_STORE] ? m_store_data :
                  m_ctrl[CTRL_IS_LOAD]  ? i_cur_dmem_data : '0;
  end

  assign wb.we     = w_ctrl[CTRL_REG_WE];
  assign wb.sel    = w_rd;
  assign wb.data   = w_ctrl[CTRL_IS_LOAD] ? w_mem_data : w_result;
  assign wb.nzp_we = w_ctrl[CTRL_NZP_WE];
  assign wb.nzp    = calc_nzp(wb.data);

  always_ff @(posedge gwe) begin
    if (i_rst) begin
      nzp_reg <= '0;
    end else if (wb.nzp_we) begin
      nzp_reg <= wb.nzp;
    end
  end

  assign o_test_stall        = w_stall;
  assign o_test_cur_pc       = w_pc;
  assign o_test_cur_insn     = w_insn;
  assign o_test_regfile_we   = wb.we;
  assign o_test_regfile_wsel = w_rd;
  assign o_test_regfile_data = wb.data;
  assign o_test_nzp_we       = wb.nzp_we;
  assign o_test_nzp_new_bits = wb.nzp;
  assign o_test_dmem_we      = w_ctrl[CTRL_IS_STORE];
  assign o_test_dmem_addr    = (w_ctrl[CTRL_IS_LOAD] || w_ctrl[CTRL_IS_STORE]) ? w_result : '0;
  assign o_test_dmem_data    = w_mem_data;  // Stored or loaded value

endmodule

`default_nettype wire

// File: rtl/lc4_hazard.sv
`timescale 1ns/1ns
`default_nettype none

module lc4_hazard import lc4_pkg::*; (
  input  wire reg_sel_t i_d_rs,
  input  wire reg_sel_t i_d_rt,
  input  wire ctrl_t    i_d_ctrl,
  input  wire reg_sel_t i_x_rs,
  input  wire reg_sel_t i_x_rt,
  input  wire reg_sel_t i_x_rd,
  input  wire ctrl_t    i_x_ctrl,
  input  wire word_t    i_x_insn,
  input  wire reg_sel_t i_m_rd,
  input  wire ctrl_t    i_m_ctrl,
  input  wire word_t    i_m_result,  // Load data when memory holds a load
  input  wire nzp_t     i_nzp_reg,
  lc4_wb_if.snoop       wb,
  output logic          o_stall,
  output logic          o_flush,
  output fwd_sel_t      o_fwd_a,
  output fwd_sel_t      o_fwd_b,
  output nzp_t          o_x_nzp
);

  logic m_fwd_ok;  // Memory stage has an ALU result ready to bypass

  // A load's data only exists in memory combinationally, never bypass its address
  assign m_fwd_ok = i_m_ctrl[CTRL_REG_WE] && !i_m_ctrl[CTRL_IS_LOAD];

  // Store data is exempt, it picks up the load result from writeback later
  assign o_stall = i_x_ctrl[CTRL_IS_LOAD] &&
                   ((i_d_ctrl[CTRL_RS_RE] && (i_d_rs == i_x_rd)) ||
                    (i_d_ctrl[CTRL_RT_RE] && !i_d_ctrl[CTRL_IS_STORE] && (i_d_rt == i_x_rd)));

  // Youngest writer wins: memory, then writeback, then register file
  assign o_fwd_a = !i_x_ctrl[CTRL_RS_RE]              ? FWD_REG :
                   (m_fwd_ok && (i_m_rd == i_x_rs))   ? FWD_MEM :
                   (wb.we && (wb.sel == i_x_rs))      ? FWD_WB  : FWD_REG;
  assign o_fwd_b = !i_x_ctrl[CTRL_RT_RE]              ? FWD_REG :
                   (m_fwd_ok && (i_m_rd == i_x_rt))   ? FWD_MEM :
                   (wb.we && (wb.sel == i_x_rt))      ? FWD_WB  : FWD_REG;

  // NZP as the branch in execute must see it
  always_comb begin
    if (i_m_ctrl[CTRL_NZP_WE]) begin
      o_x_nzp = calc_nzp(i_m_result);
    end else if (wb.nzp_we) begin
      o_x_nzp = wb.nzp;
    end else begin
      o_x_nzp = i_nzp_reg;
    end
  end

  assign o_flush = i_x_ctrl[CTRL_IS_BRANCH] && |(i_x_insn[11:9] & o_x_nzp);  // Mask hit

endmodule

`default_nettype wire

// File: rtl/lc4_alu.sv
`timescale 1ns/1ns
`default_nettype none

module lc4_alu import lc4_pkg::*; (
  input  wire alu_op_t i_alu_op,
  input  wire ctrl_t   i_ctrl,
  input  wire word_t   i_a,            // rs after forwarding
  input  wire word_t   i_b,            // rt after forwarding
  input  wire word_t   i_imm,
  input  wire word_t   i_pc_plus_one,
  output word_t        o_result,
  output word_t        o_target
);

  word_t op_b;  // Second operand, register or immediate

  assign op_b = i_ctrl[CTRL_USE_IMM] ? i_imm : i_b;

  always_comb begin
    case (i_alu_op)
      ALU_ADD:      o_result = i_a + op_b;  // Also LDR/STR address
      ALU_SUB:      o_result = i_a - op_b;
      ALU_AND:      o_result = i_a & op_b;
      ALU_NOT:      o_result = ~i_a;
      ALU_OR:       o_result = i_a | op_b;
      ALU_XOR:      o_result = i_a ^ op_b;
      ALU_PASS_IMM: o_result = i_imm;       // CONST
      default:      o_result = '0;
    endcase
  end

  // BR target, only used when the hazard unit calls the branch taken
  assign o_target = i_pc_plus_one + i_imm;

endmodule

`default_nettype wire

// File: rtl/lc4_regfile.sv
`timescale 1ns/1ns
`default_nettype none

module lc4_regfile import lc4_pkg::*; (
  input  wire           gwe,
  input  wire           i_rst,
  input  wire reg_sel_t i_rs,
  input  wire reg_sel_t i_rt,
  output word_t         o_rs_data,
  output word_t         o_rt_data,
  lc4_wb_if.wr          wb
);

  word_t regs [NUM_REGS];

  always_ff @(posedge gwe) begin
    if (i_rst) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wb.we) begin
      regs[wb.sel] <= wb.data;
    end
  end

  // Write-through so decode sees the value retiring this cycle
  assign o_rs_data = (wb.we && (wb.sel == i_rs)) ? wb.data : regs[i_rs];
  assign o_rt_data = (wb.we && (wb.sel == i_rt)) ? wb.data : regs[i_rt];

endmodule

`default_nettype wire

// File: rtl/lc4_decoder.sv
`timescale 1ns/1ns
`default_nettype none

module lc4_decoder import lc4_pkg::*; (
  input  wire word_t i_insn,
  output reg_sel_t   o_rs,
  output reg_sel_t   o_rt,
  output reg_sel_t   o_rd,
  output ctrl_t      o_ctrl,
  output alu_op_t    o_alu_op,
  output word_t      o_imm
);

  opcode_t opcode;

  assign opcode = i_insn[15:12];

  always_comb begin
    // Field positions common to most formats
    o_rs     = i_insn[8:6];
    o_rt     = i_insn[2:0];
    o_rd     = i_insn[11:9];
    o_ctrl   = '0;          // Anything unsupported falls out as a NOP
    o_alu_op = ALU_ADD;
    o_imm    = '0;
    case (opcode)
      OP_BR: begin
        o_ctrl[CTRL_IS_BRANCH] = 1'b1;       // Mask 000 is never taken
        o_imm = {{7{i_insn[8]}}, i_insn[8:0]};
      end
      OP_ARITH: begin
        if (i_insn[5]) begin                 // ADD imm5
          o_ctrl[CTRL_RS_RE]   = 1'b1;
          o_ctrl[CTRL_REG_WE]  = 1'b1;
          o_ctrl[CTRL_NZP_WE]  = 1'b1;
          o_ctrl[CTRL_USE_IMM] = 1'b1;
          o_imm = {{11{i_insn[4]}}, i_insn[4:0]};
        end else if (!i_insn[3]) begin       // ADD or SUB, MUL and DIV stay NOP
          o_ctrl[CTRL_RS_RE]  = 1'b1;
          o_ctrl[CTRL_RT_RE]  = 1'b1;
          o_ctrl[CTRL_REG_WE] = 1'b1;
          o_ctrl[CTRL_NZP_WE] = 1'b1;
          o_alu_op = i_insn[4] ? ALU_SUB : ALU_ADD;
        end
      end
      OP_LOGIC: begin
        o_ctrl[CTRL_RS_RE]  = 1'b1;
        o_ctrl[CTRL_REG_WE] = 1'b1;
        o_ctrl[CTRL_NZP_WE] = 1'b1;
        if (i_insn[5]) begin                 // AND imm5
          o_ctrl[CTRL_USE_IMM] = 1'b1;
          o_imm    = {{11{i_insn[4]}}, i_insn[4:0]};
          o_alu_op = ALU_AND;
        end else begin
          o_ctrl[CTRL_RT_RE] = (i_insn[4:3] != 2'b01);  // NOT has one source
          case (i_insn[4:3])
            2'b00:   o_alu_op = ALU_AND;
            2'b01:   o_alu_op = ALU_NOT;
            2'b10:   o_alu_op = ALU_OR;
            default: o_alu_op = ALU_XOR;
          endcase
        end
      end
      OP_LDR: begin
        o_ctrl[CTRL_RS_RE]   = 1'b1;
        o_ctrl[CTRL_REG_WE]  = 1'b1;
        o_ctrl[CTRL_NZP_WE]  = 1'b1;
        o_ctrl[CTRL_IS_LOAD] = 1'b1;
        o_ctrl[CTRL_USE_IMM] = 1'b1;         // Address is base + imm6
        o_imm = {{10{i_insn[5]}}, i_insn[5:0]};
      end
      OP_STR: begin
        o_rt = i_insn[11:9];                 // Store data sits in the rd field
        o_ctrl[CTRL_RS_RE]    = 1'b1;
        o_ctrl[CTRL_RT_RE]    = 1'b1;
        o_ctrl[CTRL_IS_STORE] = 1'b1;
        o_ctrl[CTRL_USE_IMM]  = 1'b1;
        o_imm = {{10{i_insn[5]}}, i_insn[5:0]};
      end
      OP_CONST: begin
        o_ctrl[CTRL_REG_WE]   = 1'b1;
        o_ctrl[CTRL_NZP_WE]   = 1'b1;
        o_ctrl[CTRL_USE_IMM]  = 1'b1;
        o_ctrl[CTRL_IS_CONST] = 1'b1;
        o_alu_op = ALU_PASS_IMM;
        o_imm = {{7{i_insn[8]}}, i_insn[8:0]};
      end
      default: ;
    endcase
  end

endmodule

`default_nettype wire

// File: rtl/lc4_pc.sv
`timescale 1ns/1ns
`default_nettype none

module lc4_pc import lc4_pkg::*; #(
  parameter word_t P_RESET_PC = 16'h8200  // Fetch address after reset
) (
  input  wire        gwe,
  input  wire        i_rst,
  input  wire        i_stall,     // Load-use hold
  input  wire        i_redirect,  // Taken branch in execute
  input  wire word_t i_target,
  output word_t      o_pc,
  output word_t      o_pc_plus_one
);

  assign o_pc_plus_one = o_pc + 16'd1;  // Also carried down the pipe for branches

  always_ff @(posedge gwe) begin
    if (i_rst) begin
      o_pc <= P_RESET_PC;
    end else if (i_redirect) begin
      o_pc <= i_target;      // Redirect wins over a stall
    end else if (!i_stall) begin
      o_pc <= o_pc_plus_one;
    end
  end

endmodule

`default_nettype wire

// File: rtl/lc4_wb_if.sv
`timescale 1ns/1ns
`default_nettype none

// Result of the instruction in writeback, seen by the register file and
// by the forwarding logic in the same cycle
interface lc4_wb_if import lc4_pkg::*; ();

  logic     we;      // Register write this cycle
  reg_sel_t sel;     // Destination register
  word_t    data;    // Load data or ALU result
  logic     nzp_we;
  nzp_t     nzp;     // Condition codes of data

  modport src   (output we, sel, data, nzp_we, nzp);
  modport wr    (input we, sel, data);
  modport snoop (input we, sel, nzp_we, nzp);

endinterface

`default_nettype wire

// File: rtl/lc4_pkg.sv
`default_nettype none

package lc4_pkg;

  typedef logic [15:0] word_t;     // Data, address or instruction word
  typedef logic [2:0]  reg_sel_t;  // Register index
  typedef logic [2:0]  nzp_t;      // Negative, zero, positive
  typedef logic [8:0]  ctrl_t;     // Decoded control bits, see CTRL_ indices
  typedef logic [3:0]  opcode_t;   // insn[15:12]
  typedef logic [3:0]  alu_op_t;
  typedef logic [1:0]  stall_t;    // Retirement stall code
  typedef logic [1:0]  fwd_sel_t;  // Execute operand source

  localparam int NUM_REGS = 8;

  // Opcodes of the supported subset
  localparam opcode_t OP_BR    = 4'b0000;
  localparam opcode_t OP_ARITH = 4'b0001;
  localparam opcode_t OP_LOGIC = 4'b0101;
  localparam opcode_t OP_LDR   = 4'b0110;
  localparam opcode_t OP_STR   = 4'b0111;
  localparam opcode_t OP_CONST = 4'b1001;

  // Bit positions inside ctrl_t
  localparam int CTRL_RS_RE     = 8;
  localparam int CTRL_RT_RE     = 7;
  localparam int CTRL_REG_WE    = 6;
  localparam int CTRL_NZP_WE    = 5;
  localparam int CTRL_IS_LOAD   = 4;
  localparam int CTRL_IS_STORE  = 3;
  localparam int CTRL_IS_BRANCH = 2;
  localparam int CTRL_USE_IMM   = 1;  // Second ALU operand is the immediate
  localparam int CTRL_IS_CONST  = 0;

  localparam alu_op_t ALU_ADD      = 4'd0;
  localparam alu_op_t ALU_SUB      = 4'd1;
  localparam alu_op_t ALU_AND      = 4'd2;
  localparam alu_op_t ALU_NOT      = 4'd3;
  localparam alu_op_t ALU_OR       = 4'd4;
  localparam alu_op_t ALU_XOR      = 4'd5;
  localparam alu_op_t ALU_PASS_IMM = 4'd6;

  localparam stall_t STALL_NONE  = 2'd0;
  localparam stall_t STALL_FLUSH = 2'd2;  // Bubble behind a taken branch or after reset
  localparam stall_t STALL_LOAD  = 2'd3;  // Load-use bubble

  localparam fwd_sel_t FWD_REG = 2'd0;
  localparam fwd_sel_t FWD_MEM = 2'd1;
  localparam fwd_sel_t FWD_WB  = 2'd2;

  // Condition codes of a value as it would be written to NZP
  function automatic nzp_t calc_nzp(input word_t value);
    return {value[15], value == '0, !value[15] && (value != '0)};
  endfunction

endpackage

`default_nettype wire
